/* Bender.yml */
package:
  name: audio_bridge

sources:
  - bus_pkg.sv
  - audio_pkg.sv
  - mcu_bus_if.sv
  - reg_decode.sv
  - audio_buffer.sv
  - i2s_tx.sv
  - audio_bridge_top.sv
  - target: simulation
    files:
      - tb_audio_bridge.sv

/* audio_bridge_top.sv */
/* top level: bus front end and register map on one side,
   sample buffer and I2S transmitter on the other */
module audio_bridge_top (
  input  logic                clk,
  input  logic                rst_t,
  input  bus_pkg::bus_in_t    bus_i,
  output bus_pkg::bus_word_t  dbus_o,
  output logic                dbus_oe_o,
  output audio_pkg::i2s_out_t i2s_o,
  output logic                half_irq_o
);

  // bus side
  bus_pkg::bus_access_t access;
  bus_pkg::bus_word_t   rd_data;

  // audio side
  audio_pkg::buf_write_t buf_wr;
  audio_pkg::sample_t    sample;
  logic                  fetch_req;
  logic                  fetch_ack;

  mcu_bus_if u_mcu_bus_if (
    .clk      (clk),
    .rst_t    (rst_t),
    .bus_i    (bus_i),
    .rd_data_i(rd_data),
    .access_o (access),
    .dbus_o   (dbus_o),
    .dbus_oe_o(dbus_oe_o)
  );

  reg_decode u_reg_decode (
    .clk      (clk),
    .rst_t    (rst_t),
    .access_i (access),
    .rd_data_o(rd_data),
    .buf_wr_o (buf_wr)
  );

  audio_buffer u_audio_buffer (
    .clk        (clk),
    .rst_t      (rst_t),
    .buf_wr_i   (buf_wr),
    .fetch_req_i(fetch_req),
    .fetch_ack_o(fetch_ack),
    .sample_o   (sample),
    .half_irq_o (half_irq_o)
  );

  i2s_tx u_i2s_tx (
    .clk        (clk),
    .rst_t      (rst_t),
    .fetch_ack_i(fetch_ack),
    .sample_i   (sample),
    .fetch_req_o(fetch_req),
    .i2s_o      (i2s_o)
  );

endmodule

/* audio_buffer.sv */
/* audio sample RAM with read pointer, fetch handshake
   responder and half-buffer interrupt */
module audio_buffer (
  input  logic                  clk,
  input  logic                  rst_t,
  input  audio_pkg::buf_write_t buf_wr_i,
  input  logic                  fetch_req_i,
  output logic                  fetch_ack_o,
  output audio_pkg::sample_t    sample_o,
  output logic                  half_irq_o
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_READ,
    ST_RESP,
    ST_ACK
  } fetch_state_t;

  fetch_state_t state;

  audio_pkg::sample_t   mem [audio_pkg::BUF_DEPTH];
  audio_pkg::buf_addr_t rd_ptr;
  audio_pkg::sample_t   rd_q;

  // write port from the bus, one read port for playback
  always_ff @(posedge clk) begin
    if (buf_wr_i.en) begin
      mem[buf_wr_i.addr] <= buf_wr_i.data;
    end
    if (state == ST_READ) begin
      rd_q <= mem[rd_ptr];
    end
  end

  // responder side of the four-phase fetch
  always_ff @(posedge clk) begin
    if (!rst_t) begin
      state       <= ST_IDLE;
      rd_ptr      <= '0;
      fetch_ack_o <= 1'b0;
    end else begin
      case (state)
        ST_IDLE: begin
          if (fetch_req_i) begin
            state <= ST_READ;
          end
        end
        // RAM read issued here, pointer moves on
        ST_READ: begin
          rd_ptr <= rd_ptr + 1'b1;
          state  <= ST_RESP;
        end
        ST_RESP: begin
          fetch_ack_o <= 1'b1;
          state       <= ST_ACK;
        end
        // wait for the requester to let go
        ST_ACK: begin
          if (!fetch_req_i) begin
            fetch_ack_o <= 1'b0;
            state       <= ST_IDLE;
          end
        end
        default: begin
          state <= ST_IDLE;
        end
      endcase
    end
  end

  assign sample_o = rd_q;

  // msb flips every half buffer, MCU refills the other half
  assign half_irq_o = rd_ptr[$bits(audio_pkg::buf_addr_t)-1];

  // requester must still be waiting when the answer arrives
  a_ack_needs_req: assert property (
    @(posedge clk) disable iff (!rst_t) $rose(fetch_ack_o) |-> fetch_req_i
  );

endmodule

/* audio_pkg.sv */
/* audio sample and buffer types, I2S divider constants
   and the buffer write and I2S pin structs */
package audio_pkg;

  // buffer depth in samples
  localparam int BUF_DEPTH = 1024;
  // clk cycles per half period of mclk and sclk
  localparam int MCLK_HALF = 12;
  localparam int SCLK_HALF = 192;
  // sclk periods per lrclk slot
  localparam int SLOT_BITS = 16;

  typedef logic [15:0]                    sample_t;
  typedef logic [$clog2(BUF_DEPTH)-1:0]  buf_addr_t;
  typedef logic [$clog2(MCLK_HALF)-1:0]  mclk_cnt_t;
  typedef logic [$clog2(SCLK_HALF)-1:0]  sclk_cnt_t;
  typedef logic [$clog2(SLOT_BITS)-1:0]  bit_cnt_t;

  // one write into the sample buffer
  typedef struct packed {
    buf_addr_t addr;
    sample_t   data;
    logic      en;
  } buf_write_t;

  // I2S pins toward the DAC
  typedef struct packed {
    logic mclk;
    logic sclk;
    logic lrclk;
    logic sdata;
  } i2s_out_t;

endpackage

/* bus_pkg.sv */
/* microcontroller bus types, access struct, region codes
   and register constants of the bus-side register map */
package bus_pkg;

  // one bus data word
  typedef logic [15:0] bus_word_t;

  // top five bits of the byte address
  typedef logic [4:0] region_t;

  // pins arriving from the microcontroller
  typedef struct packed {
    logic      noe;
    logic      nwe;
    logic      nadv;
    bus_word_t data;
  } bus_in_t;

  // decoded access, strobes are one cycle wide
  typedef struct packed {
    region_t   region;
    logic      rd;
    logic      wr;
    bus_word_t wdata;
  } bus_access_t;

  // byte address 0x1000
  localparam region_t REGION_ID_A       = 5'b00010;
  // byte address 0x2000
  localparam region_t REGION_ID_B       = 5'b00100;
  // 0x70xx
  localparam region_t REGION_SCRATCH    = 5'b01110;
  // 0xC0xx, write only
  localparam region_t REGION_AUDIO_DATA = 5'b11000;
  // 0xD0xx, write only
  localparam region_t REGION_AUDIO_ADDR = 5'b11010;
  // 0xF0xx, read only
  localparam region_t REGION_RANDOM     = 5'b11110;

  // identification words
  localparam bus_word_t ID_A_WORD = 16'h5555;
  localparam bus_word_t ID_B_WORD = 16'hAAAA;

  // random word holds while this counter bit is set
  localparam int RAND_STEP_BIT = 10;

endpackage

/* filelist.f */
bus_pkg.sv
audio_pkg.sv
mcu_bus_if.sv
reg_decode.sv
audio_buffer.sv
i2s_tx.sv
audio_bridge_top.sv
tb_audio_bridge.sv

/* i2s_tx.sv */
/* I2S transmitter: mclk and sclk dividers, slot counter,
   serializer with one-bit delay and the fetch requester */
module i2s_tx (
  input  logic                clk,
  input  logic                rst_t,
  input  logic                fetch_ack_i,
  input  audio_pkg::sample_t  sample_i,
  output logic                fetch_req_o,
  output audio_pkg::i2s_out_t i2s_o
);

  audio_pkg::mclk_cnt_t mclk_cnt;
  audio_pkg::sclk_cnt_t sclk_cnt;
  audio_pkg::bit_cnt_t  bit_cnt;

  logic mclk_q;
  logic sclk_q;
  logic lrclk_q;
  logic sdata_q;

  logic mclk_tick;
  logic sclk_tick;
  logic sclk_fall;

  // word fetched during the current slot
  audio_pkg::sample_t held_q;
  // shifter, msb goes out next
  audio_pkg::sample_t shift_q;

  assign mclk_tick = (mclk_cnt == audio_pkg::mclk_cnt_t'(audio_pkg::MCLK_HALF - 1));
  assign sclk_tick = (sclk_cnt == audio_pkg::sclk_cnt_t'(audio_pkg::SCLK_HALF - 1));
  assign sclk_fall = sclk_tick && sclk_q;

  // clock dividers
  always_ff @(posedge clk) begin
    if (!rst_t) begin
      mclk_cnt <= '0;
      sclk_cnt <= '0;
      mclk_q   <= 1'b0;
      sclk_q   <= 1'b0;
    end else begin
      mclk_cnt <= mclk_tick ? '0 : mclk_cnt + 1'b1;
      sclk_cnt <= sclk_tick ? '0 : sclk_cnt + 1'b1;
      if (mclk_tick) begin
        mclk_q <= ~mclk_q;
      end
      if (sclk_tick) begin
        sclk_q <= ~sclk_q;
      end
    end
  end

  // slot counter and serializer, all on sclk falling
  always_ff @(posedge clk) begin
    if (!rst_t) begin
      bit_cnt <= '0;
      lrclk_q <= 1'b0;
      sdata_q <= 1'b0;
      shift_q <= '0;
    end else if (sclk_fall) begin
      // lsb of the previous word trails the lrclk change
      sdata_q <= shift_q[15];
      if (bit_cnt == '0) begin
        lrclk_q <= ~lrclk_q;
        // halved sample, zero into the msb
        shift_q <= {1'b0, held_q[15:1]};
      end else begin
        shift_q <= {shift_q[14:0], 1'b0};
      end
      if (bit_cnt == audio_pkg::bit_cnt_t'(audio_pkg::SLOT_BITS - 1)) begin
        bit_cnt <= '0;
      end else begin
        bit_cnt <= bit_cnt + 1'b1;
      end
    end
  end

  // requester side of the fetch handshake
  always_ff @(posedge clk) begin
    if (!rst_t) begin
      fetch_req_o <= 1'b0;
      held_q      <= '0;
    end else if (fetch_req_o && fetch_ack_i) begin
      held_q      <= sample_i;
      fetch_req_o <= 1'b0;
    end else if (sclk_fall && bit_cnt == audio_pkg::bit_cnt_t'(1)) begin
      // second sclk period of the slot
      fetch_req_o <= 1'b1;
    end
  end

  assign i2s_o = '{mclk: mclk_q, sclk: sclk_q, lrclk: lrclk_q, sdata: sdata_q};

  // buffer answers before the next sclk fall, serializer never stalls
  a_req_answered: assert property (
    @(posedge clk) disable iff (!rst_t) fetch_req_o |-> !sclk_fall
  );

endmodule

/* mcu_bus_if.sv */
/* microcontroller bus front end: strobe edge detection,
   address latch, read capture and output-enable stretch */
module mcu_bus_if (
  input  logic                clk,
  input  logic                rst_t,
  input  bus_pkg::bus_in_t    bus_i,
  input  bus_pkg::bus_word_t  rd_data_i,
  output bus_pkg::bus_access_t access_o,
  output bus_pkg::bus_word_t  dbus_o,
  output logic                dbus_oe_o
);

  // two-stage edge detectors, [0] newest sample
  logic [1:0] nadv_sync;
  logic [1:0] noe_sync;
  logic [1:0] nwe_sync;

  logic nadv_rise;
  logic noe_fall;
  logic nwe_fall;

  // bus carries the word address, region comes from the byte address
  bus_pkg::bus_word_t byte_addr;
  bus_pkg::region_t   region_q;

  logic               rd_stb;
  logic               wr_stb;
  bus_pkg::bus_word_t wdata_q;

  // cycles left before the output enable drops
  logic [1:0] oe_hold;

  assign nadv_rise = (nadv_sync == 2'b01);
  assign noe_fall  = (noe_sync == 2'b10);
  assign nwe_fall  = (nwe_sync == 2'b10);
  assign byte_addr = {bus_i.data[14:0], 1'b0};

  // strobes idle high, so reset the detectors to ones
  always_ff @(posedge clk) begin
    if (!rst_t) begin
      nadv_sync <= 2'b11;
      noe_sync  <= 2'b11;
      nwe_sync  <= 2'b11;
      rd_stb    <= 1'b0;
      wr_stb    <= 1'b0;
    end else begin
      nadv_sync <= {nadv_sync[0], bus_i.nadv};
      noe_sync  <= {noe_sync[0], bus_i.noe};
      nwe_sync  <= {nwe_sync[0], bus_i.nwe};
      rd_stb    <= noe_fall;
      wr_stb    <= nwe_fall;
    end
  end

  // address phase ends on nadv rising
  always_ff @(posedge clk) begin
    if (nadv_rise) begin
      region_q <= byte_addr[15:11];
    end
    // write data is stable while nwe is low
    if (nwe_fall) begin
      wdata_q <= bus_i.data;
    end
    // read word goes out one cycle after the read strobe
    if (rd_stb) begin
      dbus_o <= rd_data_i;
    end
  end

  // enable rises with the read word, held while noe is low
  always_ff @(posedge clk) begin
    if (!rst_t) begin
      dbus_oe_o <= 1'b0;
      oe_hold   <= 2'd0;
    end else if (rd_stb || (dbus_oe_o && !noe_sync[0])) begin
      dbus_oe_o <= 1'b1;
      oe_hold   <= 2'd2;
    end else if (oe_hold != 2'd0) begin
      oe_hold <= oe_hold - 2'd1;
      if (oe_hold == 2'd1) begin
        dbus_oe_o <= 1'b0;
      end
    end
  end

  assign access_o = '{region: region_q, rd: rd_stb, wr: wr_stb, wdata: wdata_q};

  // FPGA must not drive the bus unless the MCU is reading
  a_oe_only_in_read: assert property (
    @(posedge clk) disable iff (!rst_t) $rose(dbus_oe_o) |-> !bus_i.noe
  );

endmodule

/* reg_decode.sv */
/* register map: read mux, scratch register, random word
   generator and the write port into the audio buffer */
module reg_decode (
  input  logic                 clk,
  input  logic                 rst_t,
  input  bus_pkg::bus_access_t access_i,
  output bus_pkg::bus_word_t   rd_data_o,
  output audio_pkg::buf_write_t buf_wr_o
);

  bus_pkg::bus_word_t scratch_q;
  bus_pkg::bus_word_t rand_q;

  // free-running, one bit of it gates the random step
  logic [bus_pkg::RAND_STEP_BIT:0] step_cnt;

  // held buffer address, set by the address region
  audio_pkg::buf_addr_t wr_addr;
  audio_pkg::sample_t   buf_data_q;
  logic                 buf_en_q;

  // counter and xnor LFSR, taps 15 and 3
  always_ff @(posedge clk) begin
    if (!rst_t) begin
      step_cnt <= '0;
      rand_q   <= '0;
    end else begin
      step_cnt <= step_cnt + 1'b1;
      if (!step_cnt[bus_pkg::RAND_STEP_BIT]) begin
        rand_q <= {rand_q[14:0], ~(rand_q[15] ^ rand_q[3])};
      end
    end
  end

  // register writes
  always_ff @(posedge clk) begin
    if (!rst_t) begin
      scratch_q <= '0;
      wr_addr   <= '0;
      buf_en_q  <= 1'b0;
    end else begin
      buf_en_q <= 1'b0;
      if (access_i.wr) begin
        case (access_i.region)
          bus_pkg::REGION_SCRATCH: begin
            scratch_q <= access_i.wdata;
          end
          bus_pkg::REGION_AUDIO_ADDR: begin
            wr_addr <= access_i.wdata[9:0];
          end
          // no auto-increment, address stays put
          bus_pkg::REGION_AUDIO_DATA: begin
            buf_en_q <= 1'b1;
          end
          default: begin
          end
        endcase
      end
    end
  end

  // sample data rides along with the enable
  always_ff @(posedge clk) begin
    if (access_i.wr && access_i.region == bus_pkg::REGION_AUDIO_DATA) begin
      buf_data_q <= access_i.wdata;
    end
  end

  // read mux, unmapped ranges read zero
  always_comb begin
    case (access_i.region)
      bus_pkg::REGION_ID_A:    rd_data_o = bus_pkg::ID_A_WORD;
      bus_pkg::REGION_ID_B:    rd_data_o = bus_pkg::ID_B_WORD;
      bus_pkg::REGION_SCRATCH: rd_data_o = scratch_q;
      bus_pkg::REGION_RANDOM:  rd_data_o = rand_q;
      default:                 rd_data_o = '0;
    endcase
  end

  assign buf_wr_o = '{addr: wr_addr, data: buf_data_q, en: buf_en_q};

  // xnor LFSR lock-up state is all ones
  a_rand_not_stuck: assert property (
    @(posedge clk) disable iff (!rst_t) rand_q != '1
  );

endmodule

/* tb_audio_bridge.sv */
/* testbench for the audio bridge: clock, reset, bus read and write tasks,
   I2S slot monitor and the checking assertions */
module tb_audio_bridge;
  timeunit 1ns;
  timeprecision 1ps;

  // expected divider timing, in clk cycles
  localparam int MCLK_PERIOD = 24;
  localparam int SCLK_PERIOD = 384;
  localparam int SLOT_SCLKS  = 16;
  localparam int SLOT_CYCLES = SLOT_SCLKS * SCLK_PERIOD;

  logic                clk = 1'b0;
  logic                rst_t;
  bus_pkg::bus_in_t    bus;
  bus_pkg::bus_word_t  dbus;
  logic                dbus_oe;
  audio_pkg::i2s_out_t i2s;
  logic                half_irq;

  integer      seed;
  int unsigned cycle = 0;

  // words written to buffer addresses 0..7
  logic [15:0] audio_words [8];

  // monitor state
  logic        last_lr = 1'b0;
  logic        collecting = 1'b0;
  int          bit_count = 0;
  logic [15:0] cur_word = '0;
  int          words_done = 0;
  int          slots_seen = 0;
  int          sclk_rises = 0;
  logic [15:0] slot_word [16];
  int          slot_len [16];
  logic        irq_expected;

  audio_bridge_top uut (
    .clk       (clk),
    .rst_t     (rst_t),
    .bus_i     (bus),
    .dbus_o    (dbus),
    .dbus_oe_o (dbus_oe),
    .i2s_o     (i2s),
    .half_irq_o(half_irq)
  );

  always #20 clk = ~clk;

  always @(posedge clk) begin
    cycle <= cycle + 1;
  end

  task automatic stop_run();
    $display("Test failed");
    $fatal(1, "stopped at first error");
  endtask

  task automatic report_mismatch(input string name, input logic [15:0] expected,
                                 input logic [15:0] actual);
    $display("Error: time %0t ns, signal %s, expected 0x%h, actual 0x%h",
             $time, name, expected, actual);
    stop_run();
  endtask

  task automatic report_failure(input string what);
    $display("Failure at %0t ns: %s", $time, what);
    stop_run();
  endtask

  // address phase, bus carries the word address
  task automatic set_address(input logic [15:0] byte_addr);
    @(negedge clk);
    bus.data = byte_addr >> 1;
    bus.nadv = 1'b0;
    repeat (6) @(negedge clk);
    bus.nadv = 1'b1;
    // address still needed while the latch catches up
    repeat (3) @(negedge clk);
  endtask

  task automatic bus_write(input logic [15:0] byte_addr, input logic [15:0] wdata);
    set_address(byte_addr);
    bus.data = wdata;
    bus.nwe  = 1'b0;
    repeat (6) @(negedge clk);
    bus.nwe = 1'b1;
    repeat (3) @(negedge clk);
  endtask

  task automatic bus_read(input logic [15:0] byte_addr, output logic [15:0] rdata);
    int n;
    set_address(byte_addr);
    bus.noe = 1'b0;
    repeat (6) @(negedge clk);
    // last cycle before noe rises
    assert (dbus_oe == 1'b1) else report_mismatch("dbus_oe_o", 16'd1, {15'd0, dbus_oe});
    rdata   = dbus;
    bus.noe = 1'b1;
    for (n = 0; n < 8 && dbus_oe; n++) begin
      @(negedge clk);
    end
    assert (!dbus_oe) else report_failure("dbus_oe_o still high 8 cycles after noe rose");
    assert (n <= 3) else report_failure("dbus_oe_o stayed high over 3 cycles after noe rose");
  endtask

  // rising edge of mclk or sclk, sampled on falling clk
  task automatic wait_clock_rise(input bit use_sclk, output int unsigned at_cycle);
    logic prev;
    logic now_v;
    int   n;
    bit   seen;
    seen     = 1'b0;
    at_cycle = 0;
    prev     = use_sclk ? i2s.sclk : i2s.mclk;
    for (n = 0; n < 2 * SCLK_PERIOD && !seen; n++) begin
      @(negedge clk);
      now_v = use_sclk ? i2s.sclk : i2s.mclk;
      if (!prev && now_v) begin
        seen     = 1'b1;
        at_cycle = cycle;
      end
      prev = now_v;
    end
    if (!seen) begin
      report_failure(use_sclk ? "timeout waiting for sclk to rise"
                              : "timeout waiting for mclk to rise");
    end
  endtask

  task automatic wait_for_slots(input int count);
    int n;
    for (n = 0; n < (count + 2) * SLOT_CYCLES && slots_seen < count; n++) begin
      @(negedge clk);
    end
    if (slots_seen < count) begin
      report_failure("timeout waiting for I2S slots");
    end
  endtask

  // sdata stable on sclk rising, lrclk edges mark slot starts
  always @(posedge i2s.sclk) begin
    if (rst_t) begin
      sclk_rises = sclk_rises + 1;
      // first bit after an lrclk change still belongs to the previous slot
      if (collecting) begin
        cur_word  = {cur_word[14:0], i2s.sdata};
        bit_count = bit_count + 1;
        if (bit_count == 16) begin
          if (words_done < 16) begin
            slot_word[words_done] = cur_word;
          end
          words_done = words_done + 1;
          collecting = 1'b0;
        end
      end
      if (i2s.lrclk !== last_lr) begin
        // one fetch per slot, none yet for this one
        irq_expected = (slots_seen >= 512);
        assert (half_irq == irq_expected)
          else report_mismatch("half_irq_o", {15'd0, irq_expected}, {15'd0, half_irq});
        // sclk periods since the previous lrclk change
        if (slots_seen < 16) begin
          slot_len[slots_seen] = sclk_rises;
        end
        sclk_rises = 0;
        last_lr    = i2s.lrclk;
        slots_seen = slots_seen + 1;
        collecting = 1'b1;
        bit_count  = 0;
        cur_word   = '0;
      end
    end
  end

  // serial data and word select move only with sclk falling
  i2s_edges: assert property (
    @(posedge clk) disable iff (!rst_t)
    ($changed(i2s.sdata) || $changed(i2s.lrclk)) |-> $fell(i2s.sclk)
  ) else report_failure("sdata or lrclk changed away from a falling sclk edge");

  initial begin
    logic [15:0] rd;
    logic [15:0] scratch;
    logic [15:0] rand_a;
    logic [15:0] rand_b;
    logic [15:0] expected;
    int unsigned t1;
    int unsigned t2;
    int          i;

    seed  = 38789;
    rst_t = 1'b0;
    bus   = '{noe: 1'b1, nwe: 1'b1, nadv: 1'b1, data: 16'h0000};
    repeat (4) @(negedge clk);
    rst_t = 1'b1;
    @(negedge clk);

    // reset state of the outputs
    assert (dbus_oe == 1'b0) else report_mismatch("dbus_oe_o", 16'd0, {15'd0, dbus_oe});
    assert (half_irq == 1'b0) else report_mismatch("half_irq_o", 16'd0, {15'd0, half_irq});
    assert (i2s.mclk == 1'b0) else report_mismatch("mclk", 16'd0, {15'd0, i2s.mclk});
    assert (i2s.sclk == 1'b0) else report_mismatch("sclk", 16'd0, {15'd0, i2s.sclk});
    assert (i2s.lrclk == 1'b0) else report_mismatch("lrclk", 16'd0, {15'd0, i2s.lrclk});
    assert (i2s.sdata == 1'b0) else report_mismatch("sdata", 16'd0, {15'd0, i2s.sdata});

    // fill buffer words 0..7 before the first fetch
    for (i = 0; i < 8; i++) begin
      audio_words[i] = $random(seed);
      bus_write(16'hD000, 16'(i));
      bus_write(16'hC000, audio_words[i]);
    end

    // ID words, unmapped ranges, scratch
    bus_read(16'h1000, rd);
    assert (rd == 16'h5555) else report_mismatch("dbus_o", 16'h5555, rd);
    bus_read(16'h2000, rd);
    assert (rd == 16'hAAAA) else report_mismatch("dbus_o", 16'hAAAA, rd);
    bus_read(16'h4000, rd);
    assert (rd == 16'h0000) else report_mismatch("dbus_o", 16'h0000, rd);
    bus_read(16'hC000, rd);
    assert (rd == 16'h0000) else report_mismatch("dbus_o", 16'h0000, rd);
    scratch = $random(seed);
    bus_write(16'h7000, scratch);
    bus_read(16'h7000, rd);
    assert (rd == scratch) else report_mismatch("dbus_o", scratch, rd);

    // random word, two reads far apart
    bus_read(16'hF000, rand_a);
    assert (rand_a != 16'hFFFF) else report_failure("random word read as 0xFFFF");
    repeat (2100) @(negedge clk);
    bus_read(16'hF000, rand_b);
    assert (rand_b != 16'hFFFF) else report_failure("random word read as 0xFFFF");
    assert (rand_b != rand_a) else report_failure("random word unchanged after 2048 cycles");

    // divider periods
    wait_clock_rise(1'b0, t1);
    wait_clock_rise(1'b0, t2);
    assert (t2 - t1 == MCLK_PERIOD) else report_mismatch("mclk period", 16'(MCLK_PERIOD),
                                                         16'(t2 - t1));
    wait_clock_rise(1'b1, t1);
    wait_clock_rise(1'b1, t2);
    assert (t2 - t1 == SCLK_PERIOD) else report_mismatch("sclk period", 16'(SCLK_PERIOD),
                                                         16'(t2 - t1));

    // slot 0 is silent, slot k carries word k-1 halved
    wait_for_slots(10);
    assert (slot_word[0] == 16'h0000) else report_mismatch("slot 0 word", 16'h0000,
                                                           slot_word[0]);
    for (i = 1; i <= 8; i++) begin
      expected = {1'b0, audio_words[i-1][15:1]};
      assert (slot_word[i] == expected) else report_mismatch("slot word", expected,
                                                             slot_word[i]);
      // lrclk flips once every slot
      assert (slot_len[i] == SLOT_SCLKS) else report_mismatch("lrclk slot length",
                                                              16'(SLOT_SCLKS),
                                                              16'(slot_len[i]));
    end

    // half buffer interrupt, checked by the monitor at each slot start
    wait_for_slots(513);

    $display("Test passed");
    $finish;
  end

endmodule
